//--- all.f
+incdir+design
design/mpu_types_pkg.sv
design/mpu_isa_pkg.sv
design/mpu_decode.sv
design/mpu_matrix_regfile.sv
design/mpu_load.sv
design/mpu_store.sv
design/mpu_elem_alu.sv
design/mpu_writeback.sv
design/mpu_top.sv
dv/tb_mpu.sv

//--- design/mpu_decode.sv
`timescale 1ns/1ps

module mpu_decode
    import mpu_isa_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   instr_valid,
    input  instr_t instr,
    input  logic   finish,
    output logic   busy,
    output logic   done,
    output instr_t active_instr,
    output unit_e  active_unit,
    output logic   start_load,
    output logic   start_store,
    output logic   start_alu
);

    logic accept;

    // New work only when idle, valid is a level
    assign accept = instr_valid && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            done        <= 1'b0;
            active_unit <= UNIT_NONE;
            start_load  <= 1'b0;
            start_store <= 1'b0;
            start_alu   <= 1'b0;
        end else begin
            start_load  <= 1'b0;  // Strobes are one cycle wide
            start_store <= 1'b0;
            start_alu   <= 1'b0;
            done        <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                unique case (instr.opcode)
                    OP_LOAD: begin
                        active_unit <= UNIT_LOAD;
                        start_load  <= 1'b1;
                    end
                    OP_STORE: begin
                        active_unit <= UNIT_STORE;
                        start_store <= 1'b1;
                    end
                    default: begin  // ADD and SUB
                        active_unit <= UNIT_ALU;
                        start_alu   <= 1'b1;
                    end
                endcase
            end else if (busy && finish) begin
                busy        <= 1'b0;  // Falls together with done
                done        <= 1'b1;
                active_unit <= UNIT_NONE;
            end
        end
    end

    // Held for the units until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            active_instr <= instr;
        end
    end

endmodule : mpu_decode

//--- design/mpu_elem_alu.sv
`timescale 1ns/1ps

module mpu_elem_alu
    import mpu_types_pkg::*;
    import mpu_isa_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  instr_t     instr,
    input  size_t      a_size,
    output rf_rd_req_t rd_req_a,
    output rf_rd_req_t rd_req_b,
    input  elem_t      rd_data_a,
    input  elem_t      rd_data_b,
    output rf_wr_req_t wr_req,
    output logic       finish
);

    seq_state_e state;
    row_idx_t   row;
    col_idx_t   col;
    logic       active;
    logic       row_end, col_end, last;
    elem_t      result;

    // Walk follows src_a only
    assign active  = start || (state == SEQ_RUN);
    assign row_end = ({1'b0, row} == a_size.rows - 3'd1);
    assign col_end = ({1'b0, col} == a_size.cols - 3'd1);
    assign last    = row_end && col_end;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEQ_IDLE;
            row   <= '0;
            col   <= '0;
        end else if (active) begin
            if (last) begin
                state <= SEQ_IDLE;
                row   <= '0;
                col   <= '0;
            end else begin
                state <= SEQ_RUN;
                if (col_end) begin
                    row <= row + 1'b1;
                    col <= '0;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // Same location from both sources
    assign rd_req_a = '{id: instr.src_a, row: row, col: col};
    assign rd_req_b = '{id: instr.src_b, row: row, col: col};

    // Wrap-around integer arithmetic
    assign result = (instr.opcode == OP_SUB) ? rd_data_a - rd_data_b
                                             : rd_data_a + rd_data_b;

    // Read this cycle, write at the edge, so dst may alias a source
    always_comb begin
        wr_req         = '0;
        wr_req.en      = active;
        wr_req.id      = instr.dst;
        wr_req.row     = row;
        wr_req.col     = col;
        wr_req.data    = result;
        wr_req.size_we = start;
        wr_req.size    = a_size;
    end

    assign finish = active && last;

endmodule : mpu_elem_alu

//--- design/mpu_isa_pkg.sv
`include "mpu_macros.svh"

package mpu_isa_pkg;

    import mpu_types_pkg::*;

    // ---------------------------------------------------------------------------
    // Instruction format
    // ---------------------------------------------------------------------------

    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,  // Memory to register
        OP_STORE = 2'd1,  // Register to memory
        OP_ADD   = 2'd2,
        OP_SUB   = 2'd3
    } opcode_e;

    typedef struct packed {
        opcode_e                 opcode;
        reg_id_t                 dst;
        reg_id_t                 src_a;     // Also the store source
        reg_id_t                 src_b;
        logic [`MPU_ADDR_W-1:0]  mem_addr;  // Base of row-major block
        size_t                   size;      // Used by LOAD only
    } instr_t;

    // ---------------------------------------------------------------------------
    // Control encodings
    // ---------------------------------------------------------------------------

    typedef enum logic [1:0] {
        UNIT_NONE  = 2'd0,
        UNIT_LOAD  = 2'd1,
        UNIT_STORE = 2'd2,
        UNIT_ALU   = 2'd3
    } unit_e;

    // Shared by the load, store and ALU walkers
    typedef enum logic {
        SEQ_IDLE = 1'b0,
        SEQ_RUN  = 1'b1
    } seq_state_e;

endpackage : mpu_isa_pkg

//--- design/mpu_load.sv
`timescale 1ns/1ps

`include "mpu_macros.svh"

module mpu_load
    import mpu_types_pkg::*;
    import mpu_isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  instr_t                 instr,
    output logic                   mem_rd_en,
    output logic [`MPU_ADDR_W-1:0] mem_rd_addr,
    input  elem_t                  mem_rd_data,
    output rf_wr_req_t             wr_req,
    output logic                   finish
);

    seq_state_e state;
    row_idx_t   row, row_q;
    col_idx_t   col, col_q;
    logic       issue;
    logic       row_end, col_end, last;
    logic       vld_q, last_q;  // Read issued last cycle

    assign issue   = start || (state == SEQ_RUN);
    assign row_end = ({1'b0, row} == instr.size.rows - 3'd1);
    assign col_end = ({1'b0, col} == instr.size.cols - 3'd1);
    assign last    = row_end && col_end;

    // Row-major, fixed stride of MPU_MAX_N
    assign mem_rd_en   = issue;
    assign mem_rd_addr = instr.mem_addr + `MPU_ADDR_W'(int'(row) * `MPU_MAX_N + int'(col));

    // ---------------------------------------------------------------------------
    // Read walker
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= SEQ_IDLE;
            row    <= '0;
            col    <= '0;
            vld_q  <= 1'b0;
            last_q <= 1'b0;
        end else begin
            vld_q  <= issue;
            last_q <= issue && last;
            if (issue) begin
                if (last) begin
                    state <= SEQ_IDLE;
                    row   <= '0;
                    col   <= '0;
                end else begin
                    state <= SEQ_RUN;
                    if (col_end) begin
                        row <= row + 1'b1;
                        col <= '0;
                    end else begin
                        col <= col + 1'b1;
                    end
                end
            end
        end
    end

    // Location travels with the returning word
    always_ff @(posedge clk) begin
        row_q <= row;
        col_q <= col;
    end

    always_comb begin
        wr_req         = '0;
        wr_req.en      = vld_q;
        wr_req.id      = instr.dst;
        wr_req.row     = row_q;
        wr_req.col     = col_q;
        wr_req.data    = mem_rd_data;
        wr_req.size_we = start;  // Size goes in with the first read
        wr_req.size    = instr.size;
    end

    assign finish = vld_q && last_q;

endmodule : mpu_load

//--- design/mpu_macros.svh
`ifndef MPU_MACROS_SVH
`define MPU_MACROS_SVH

// ---------------------------------------------------------------------------
// Matrix unit dimensions
// ---------------------------------------------------------------------------

`define MPU_ELEM_W    32  // Element width in bits
`define MPU_MAX_M     4   // Max rows per matrix
`define MPU_MAX_N     4   // Max columns, also the memory row stride
`define MPU_NUM_REGS  4   // Matrix registers in the file
`define MPU_ADDR_W    8   // External word address width

`endif

//--- design/mpu_matrix_regfile.sv
`timescale 1ns/1ps

`include "mpu_macros.svh"

module mpu_matrix_regfile
    import mpu_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  rf_wr_req_t wr,
    input  rf_rd_req_t rd0,
    input  rf_rd_req_t rd1,
    output elem_t      rd0_data,
    output elem_t      rd1_data,
    output size_t      size_of [`MPU_NUM_REGS]
);

    elem_t mats [`MPU_NUM_REGS][`MPU_MAX_M][`MPU_MAX_N];

    // Combinational reads
    assign rd0_data = mats[rd0.id][rd0.row][rd0.col];
    assign rd1_data = mats[rd1.id][rd1.row][rd1.col];

    // ---------------------------------------------------------------------------
    // Write port, elements and sizes
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `MPU_NUM_REGS; r++) begin
                size_of[r] <= '{rows: 3'd1, cols: 3'd1};  // Every register 1 by 1
                for (int i = 0; i < `MPU_MAX_M; i++) begin
                    for (int j = 0; j < `MPU_MAX_N; j++) begin
                        mats[r][i][j] <= '0;
                    end
                end
            end
        end else begin
            if (wr.en) begin
                mats[wr.id][wr.row][wr.col] <= wr.data;
            end
            // Size may land in a cycle with no element
            if (wr.size_we) begin
                size_of[wr.id] <= wr.size;
            end
        end
    end

endmodule : mpu_matrix_regfile

//--- design/mpu_store.sv
`timescale 1ns/1ps

`include "mpu_macros.svh"

module mpu_store
    import mpu_types_pkg::*;
    import mpu_isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  instr_t                 instr,
    input  size_t                  src_size,     // Stored size of src_a
    output rf_rd_req_t             rd_req,
    input  elem_t                  rd_data,
    output logic                   mem_wr_en,
    output logic [`MPU_ADDR_W-1:0] mem_wr_addr,
    output elem_t                  mem_wr_data,
    output logic                   finish
);

    seq_state_e state;
    row_idx_t   row_ptr;
    col_idx_t   col_ptr;
    logic       store_active;
    logic       row_end, col_end, store_last;

    // ---------------------------------------------------------------------------
    // Pointers and end of transfer
    // ---------------------------------------------------------------------------

    assign store_active = start || (state == SEQ_RUN);
    assign row_end      = ({1'b0, row_ptr} == src_size.rows - 3'd1);
    assign col_end      = ({1'b0, col_ptr} == src_size.cols - 3'd1);
    assign store_last   = row_end && col_end;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= SEQ_IDLE;
            row_ptr <= '0;
            col_ptr <= '0;
        end else if (store_active) begin
            if (store_last) begin
                state   <= SEQ_IDLE;  // Back to origin for the next store
                row_ptr <= '0;
                col_ptr <= '0;
            end else if (col_end) begin
                state   <= SEQ_RUN;
                row_ptr <= row_ptr + 1'b1;
                col_ptr <= '0;
            end else begin
                state   <= SEQ_RUN;
                col_ptr <= col_ptr + 1'b1;
            end
        end
    end

    // One element per cycle, read straight through
    assign rd_req = '{id: instr.src_a, row: row_ptr, col: col_ptr};

    assign mem_wr_en   = store_active;
    assign mem_wr_data = rd_data;
    assign mem_wr_addr = instr.mem_addr
                       + `MPU_ADDR_W'(int'(row_ptr) * `MPU_MAX_N + int'(col_ptr));

    assign finish = store_active && store_last;  // Marks the last element

endmodule : mpu_store

//--- design/mpu_top.sv
`timescale 1ns/1ps

`include "mpu_macros.svh"

module mpu_top
    import mpu_types_pkg::*;
    import mpu_isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  instr_t                 instr,
    output logic                   busy,
    output logic                   done,
    output logic                   mem_rd_en,
    output logic [`MPU_ADDR_W-1:0] mem_rd_addr,
    input  elem_t                  mem_rd_data,
    output logic                   mem_wr_en,
    output logic [`MPU_ADDR_W-1:0] mem_wr_addr,
    output elem_t                  mem_wr_data
);

    instr_t     active_instr;
    unit_e      active_unit;
    logic       start_load, start_store, start_alu;
    logic       load_fin, store_fin, alu_fin, finish;
    rf_wr_req_t load_wr, alu_wr, rf_wr;
    rf_rd_req_t store_rd, alu_rd_a, alu_rd_b, rf_rd0;
    elem_t      rd0_data, rd1_data;
    size_t      size_of [`MPU_NUM_REGS];
    size_t      src_a_size;

    // Both the store and the ALU walk the size of src_a
    assign src_a_size = size_of[active_instr.src_a];

    // ---------------------------------------------------------------------------
    // Control
    // ---------------------------------------------------------------------------

    mpu_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .finish       (finish),
        .busy         (busy),
        .done         (done),
        .active_instr (active_instr),
        .active_unit  (active_unit),
        .start_load   (start_load),
        .start_store  (start_store),
        .start_alu    (start_alu)
    );

    // ---------------------------------------------------------------------------
    // Execute units
    // ---------------------------------------------------------------------------

    mpu_load u_load (
        .clk         (clk),
        .rst         (rst),
        .start       (start_load),
        .instr       (active_instr),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_data (mem_rd_data),
        .wr_req      (load_wr),
        .finish      (load_fin)
    );

    mpu_store u_store (
        .clk         (clk),
        .rst         (rst),
        .start       (start_store),
        .instr       (active_instr),
        .src_size    (src_a_size),
        .rd_req      (store_rd),
        .rd_data     (rd0_data),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .finish      (store_fin)
    );

    mpu_elem_alu u_alu (
        .clk       (clk),
        .rst       (rst),
        .start     (start_alu),
        .instr     (active_instr),
        .a_size    (src_a_size),
        .rd_req_a  (alu_rd_a),
        .rd_req_b  (alu_rd_b),
        .rd_data_a (rd0_data),
        .rd_data_b (rd1_data),
        .wr_req    (alu_wr),
        .finish    (alu_fin)
    );

    mpu_writeback u_writeback (
        .active_unit (active_unit),
        .load_wr     (load_wr),
        .alu_wr      (alu_wr),
        .store_rd    (store_rd),
        .alu_rd      (alu_rd_a),
        .load_fin    (load_fin),
        .store_fin   (store_fin),
        .alu_fin     (alu_fin),
        .rf_wr       (rf_wr),
        .rf_rd0      (rf_rd0),
        .finish      (finish)
    );

    mpu_matrix_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .wr       (rf_wr),
        .rd0      (rf_rd0),
        .rd1      (alu_rd_b),  // Port 1 belongs to ALU operand B
        .rd0_data (rd0_data),
        .rd1_data (rd1_data),
        .size_of  (size_of)
    );

endmodule : mpu_top

//--- design/mpu_types_pkg.sv
`include "mpu_macros.svh"

package mpu_types_pkg;

    // One matrix element, plain two's complement word
    typedef logic [`MPU_ELEM_W-1:0] elem_t;

    typedef logic [$clog2(`MPU_MAX_M)-1:0] row_idx_t;
    typedef logic [$clog2(`MPU_MAX_N)-1:0] col_idx_t;
    typedef logic [$clog2(`MPU_NUM_REGS)-1:0] reg_id_t;

    // Counts run 1 to max, hence the extra bit
    typedef struct packed {
        logic [$clog2(`MPU_MAX_M):0] rows;
        logic [$clog2(`MPU_MAX_N):0] cols;
    } size_t;

    typedef struct packed {
        reg_id_t  id;
        row_idx_t row;
        col_idx_t col;
    } rf_rd_req_t;

    // Element write and size write share one request
    typedef struct packed {
        logic     en;       // Element write enable
        reg_id_t  id;
        row_idx_t row;
        col_idx_t col;
        elem_t    data;
        logic     size_we;  // Size write enable, independent of en
        size_t    size;
    } rf_wr_req_t;

endpackage : mpu_types_pkg

//--- design/mpu_writeback.sv
`timescale 1ns/1ps

module mpu_writeback
    import mpu_types_pkg::*;
    import mpu_isa_pkg::*;
(
    input  unit_e      active_unit,
    input  rf_wr_req_t load_wr,
    input  rf_wr_req_t alu_wr,
    input  rf_rd_req_t store_rd,
    input  rf_rd_req_t alu_rd,
    input  logic       load_fin,
    input  logic       store_fin,
    input  logic       alu_fin,
    output rf_wr_req_t rf_wr,
    output rf_rd_req_t rf_rd0,
    output logic       finish
);

    // Only the active unit reaches the register file
    always_comb begin
        rf_wr  = '0;
        rf_rd0 = '0;
        unique case (active_unit)
            UNIT_LOAD:  rf_wr = load_wr;
            UNIT_STORE: rf_rd0 = store_rd;
            UNIT_ALU: begin
                rf_wr  = alu_wr;
                rf_rd0 = alu_rd;  // B read bypasses this mux
            end
            default: begin
                rf_wr  = '0;
                rf_rd0 = '0;
            end
        endcase
    end

    assign finish = load_fin | store_fin | alu_fin;

endmodule : mpu_writeback

//--- dv/tb_mpu.sv
`timescale 1ns/1ps

`include "mpu_macros.svh"

module tb_mpu
    import mpu_types_pkg::*;
    import mpu_isa_pkg::*;
();

    localparam int CLK_PERIOD    = 4;
    localparam int INSTR_TIMEOUT = 40;  // Cycles allowed per instruction
    localparam int ALU_OPS       = 12;
    localparam int RAND_OPS      = 60;
    localparam int NUM_INSTR     = 8 + 2 * ALU_OPS + 6 + 6 + RAND_OPS;
    localparam int WATCHDOG_CYC  = NUM_INSTR * INSTR_TIMEOUT + 200;
    localparam int MEM_WORDS     = 1 << `MPU_ADDR_W;

    logic                   clk;
    logic                   rst;
    logic                   instr_valid;
    instr_t                 instr;
    logic                   busy;
    logic                   done;
    logic                   mem_rd_en;
    logic [`MPU_ADDR_W-1:0] mem_rd_addr;
    elem_t                  mem_rd_data;
    logic                   mem_wr_en;
    logic [`MPU_ADDR_W-1:0] mem_wr_addr;
    elem_t                  mem_wr_data;

    elem_t mem [MEM_WORDS];      // Memory seen by the DUT
    elem_t exp_mem [MEM_WORDS];  // Expected memory contents
    elem_t model_mat [`MPU_NUM_REGS][`MPU_MAX_M * `MPU_MAX_N];
    size_t model_size [`MPU_NUM_REGS];

    logic [`MPU_ADDR_W-1:0] wr_log [$];  // Write addresses of one instruction
    logic [`MPU_ADDR_W-1:0] rd_log [$];  // Read addresses of one instruction
    logic                   rd_en_s;
    logic [`MPU_ADDR_W-1:0] rd_addr_s;

    int errors;
    int tests_run;
    int tests_failed;

    mpu_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .busy        (busy),
        .done        (done),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_data (mem_rd_data),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ---------------------------------------------------------------------------
    // Memory model with writes at the edge and read data one cycle later
    // ---------------------------------------------------------------------------

    always @(posedge clk) begin
        rd_en_s   = mem_rd_en;
        rd_addr_s = mem_rd_addr;
        if (mem_wr_en === 1'b1) begin
            mem[mem_wr_addr] = mem_wr_data;
            wr_log.push_back(mem_wr_addr);
        end
        if (mem_rd_en === 1'b1) begin
            rd_log.push_back(mem_rd_addr);
        end
        #1;
        if (rd_en_s === 1'b1) begin
            mem_rd_data = mem[rd_addr_s];
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;  // Drive and sample point
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
        errors++;
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - err_before);
        end
    endtask

    function automatic size_t random_size();
        size_t s;
        s.rows = 3'($urandom % 4 + 1);
        s.cols = 3'($urandom % 4 + 1);
        return s;
    endfunction

    function automatic instr_t random_instr();
        instr_t ins;
        ins.opcode   = opcode_e'(2'($urandom % 4));
        ins.dst      = reg_id_t'($urandom % 4);
        ins.src_a    = reg_id_t'($urandom % 4);
        ins.src_b    = reg_id_t'($urandom % 4);
        ins.mem_addr = `MPU_ADDR_W'($urandom);
        ins.size     = random_size();
        return ins;
    endfunction

    // Address of the k-th element in row-major order, wrapping at the top
    function automatic logic [`MPU_ADDR_W-1:0] row_major_addr(
        input logic [`MPU_ADDR_W-1:0] base,
        input int                     cols,
        input int                     k
    );
        return base + `MPU_ADDR_W'((k / cols) * `MPU_MAX_N + k % cols);
    endfunction

    // Register model in row-major order with stride MPU_MAX_N
    task automatic apply_to_model(input instr_t ins);
        size_t                  sz;
        int                     idx;
        logic [`MPU_ADDR_W-1:0] addr;
        sz = (ins.opcode == OP_LOAD) ? ins.size : model_size[ins.src_a];
        for (int r = 0; r < int'(sz.rows); r++) begin
            for (int c = 0; c < int'(sz.cols); c++) begin
                idx  = r * `MPU_MAX_N + c;
                addr = ins.mem_addr + `MPU_ADDR_W'(idx);
                case (ins.opcode)
                    OP_LOAD:  model_mat[ins.dst][idx] = exp_mem[addr];
                    OP_STORE: exp_mem[addr] = model_mat[ins.src_a][idx];
                    OP_ADD: begin
                        model_mat[ins.dst][idx] = model_mat[ins.src_a][idx]
                                                + model_mat[ins.src_b][idx];
                    end
                    default: begin
                        model_mat[ins.dst][idx] = model_mat[ins.src_a][idx]
                                                - model_mat[ins.src_b][idx];
                    end
                endcase
            end
        end
        if (ins.opcode != OP_STORE) begin
            model_size[ins.dst] = sz;  // ALU result takes the size of src_a
        end
    endtask

    task automatic compare_memory();
        for (int a = 0; a < MEM_WORDS; a++) begin
            if (mem[a] !== exp_mem[a]) begin
                report_mismatch($sformatf("mem[0x%02h]", a[7:0]), mem[a], exp_mem[a]);
            end
        end
    endtask

    // ---------------------------------------------------------------------------
    // One instruction and an optional competing instr_valid while busy
    // ---------------------------------------------------------------------------

    task automatic execute_instr(input instr_t ins, input bit intrude);
        size_t                  sz;
        int                     elems;
        int                     latency;
        int                     exp_writes;
        int                     exp_reads;
        int                     cycle;
        logic [`MPU_ADDR_W-1:0] exp_addr;
        instr_t                 other;
        sz         = (ins.opcode == OP_LOAD) ? ins.size : model_size[ins.src_a];
        elems      = int'(sz.rows) * int'(sz.cols);
        latency    = (ins.opcode == OP_LOAD) ? elems + 2 : elems + 1;
        exp_writes = (ins.opcode == OP_STORE) ? elems : 0;
        exp_reads  = (ins.opcode == OP_LOAD) ? elems : 0;
        wr_log.delete();
        rd_log.delete();
        instr       = ins;
        instr_valid = 1'b1;
        next_cycle();  // Accept edge has passed
        if (intrude) begin
            other          = random_instr();
            other.mem_addr = ~ins.mem_addr;
            instr          = other;  // Valid stays high while busy
        end else begin
            instr_valid = 1'b0;
        end
        if (busy !== 1'b1) report_mismatch("busy", 32'(busy), 32'h1);
        cycle = 1;
        while (done !== 1'b1 && cycle <= INSTR_TIMEOUT) begin
            next_cycle();
            cycle++;
        end
        instr_valid = 1'b0;
        if (done !== 1'b1) begin
            $display("No done from the DUT within %0d cycles for opcode %0d",
                     INSTR_TIMEOUT, ins.opcode);
            errors++;
            return;
        end
        if (cycle != latency) report_mismatch("done cycle", 32'(cycle), 32'(latency));
        if (busy !== 1'b0) report_mismatch("busy", 32'(busy), 32'h0);
        if (wr_log.size() != exp_writes) begin
            report_mismatch("mem_wr_en count", 32'(wr_log.size()), 32'(exp_writes));
        end else begin
            for (int k = 0; k < exp_writes; k++) begin
                exp_addr = row_major_addr(ins.mem_addr, int'(sz.cols), k);
                if (wr_log[k] !== exp_addr) begin
                    report_mismatch("mem_wr_addr", 32'(wr_log[k]), 32'(exp_addr));
                end
            end
        end
        if (rd_log.size() != exp_reads) begin
            report_mismatch("mem_rd_en count", 32'(rd_log.size()), 32'(exp_reads));
        end else begin
            for (int k = 0; k < exp_reads; k++) begin
                exp_addr = row_major_addr(ins.mem_addr, int'(sz.cols), k);
                if (rd_log[k] !== exp_addr) begin
                    report_mismatch("mem_rd_addr", 32'(rd_log[k]), 32'(exp_addr));
                end
            end
        end
        apply_to_model(ins);
        next_cycle();
        if (done !== 1'b0) report_mismatch("done", 32'(done), 32'h0);  // Single pulse
        if (busy !== 1'b0) report_mismatch("busy", 32'(busy), 32'h0);
        compare_memory();
    endtask

    // ---------------------------------------------------------------------------
    // Tests
    // ---------------------------------------------------------------------------

    task automatic reset_idle();
        int e0;
        e0 = errors;
        repeat (8) begin
            next_cycle();
            if (busy !== 1'b0) report_mismatch("busy", 32'(busy), 32'h0);
            if (done !== 1'b0) report_mismatch("done", 32'(done), 32'h0);
            if (mem_rd_en !== 1'b0) report_mismatch("mem_rd_en", 32'(mem_rd_en), 32'h0);
            if (mem_wr_en !== 1'b0) report_mismatch("mem_wr_en", 32'(mem_wr_en), 32'h0);
        end
        report_test("reset_idle", e0);
    endtask

    task automatic round_trip();
        int     e0;
        instr_t ins;
        size_t  sz [`MPU_NUM_REGS];
        int     src;
        int     dst;
        e0 = errors;
        for (int k = 0; k < `MPU_NUM_REGS; k++) begin
            ins          = '0;
            ins.opcode   = OP_LOAD;
            ins.dst      = reg_id_t'(k);
            ins.mem_addr = `MPU_ADDR_W'(k * 16);
            ins.size     = random_size();
            sz[k]        = ins.size;
            execute_instr(ins, 1'b0);
        end
        for (int k = 0; k < `MPU_NUM_REGS; k++) begin
            ins          = '0;
            ins.opcode   = OP_STORE;
            ins.src_a    = reg_id_t'(k);
            ins.mem_addr = `MPU_ADDR_W'(128 + k * 16);
            execute_instr(ins, 1'b0);
        end
        // Stored copy against the loaded source area
        for (int k = 0; k < `MPU_NUM_REGS; k++) begin
            for (int r = 0; r < int'(sz[k].rows); r++) begin
                for (int c = 0; c < int'(sz[k].cols); c++) begin
                    src = k * 16 + r * `MPU_MAX_N + c;
                    dst = 128 + src;
                    if (mem[dst] !== mem[src]) begin
                        report_mismatch($sformatf("mem[0x%02h]", dst[7:0]), mem[dst], mem[src]);
                    end
                end
            end
        end
        report_test("round_trip", e0);
    endtask

    task automatic add_sub_mix();
        int     e0;
        instr_t ins;
        instr_t st;
        e0 = errors;
        for (int i = 0; i < ALU_OPS; i++) begin
            ins        = random_instr();
            ins.opcode = (i % 2 == 1) ? OP_SUB : OP_ADD;
            if (i % 3 == 0) ins.dst = ins.src_a;
            if (i % 3 == 1) ins.dst = ins.src_b;
            execute_instr(ins, 1'b0);
            st          = random_instr();
            st.opcode   = OP_STORE;
            st.src_a    = ins.dst;
            execute_instr(st, 1'b0);
        end
        report_test("add_sub_mix", e0);
    endtask

    task automatic store_order();
        int     e0;
        instr_t ins;
        e0 = errors;
        for (int i = 0; i < 3; i++) begin
            ins        = random_instr();
            ins.opcode = OP_LOAD;
            ins.dst    = reg_id_t'(i);
            execute_instr(ins, 1'b0);
            ins.opcode   = OP_STORE;
            ins.src_a    = reg_id_t'(i);
            ins.mem_addr = `MPU_ADDR_W'(8'hf6 + i);  // Near the top so larger blocks wrap
            execute_instr(ins, 1'b0);
        end
        report_test("store_order", e0);
    endtask

    task automatic busy_done_protocol();
        int e0;
        e0 = errors;
        repeat (6) execute_instr(random_instr(), 1'b1);
        report_test("busy_done_protocol", e0);
    endtask

    task automatic random_sequence();
        int e0;
        e0 = errors;
        repeat (RAND_OPS) execute_instr(random_instr(), 1'b0);
        report_test("random_sequence", e0);
    endtask

    initial begin
        void'($urandom(32'h9d39ed8f));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        mem_rd_data  = '0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a]     = $urandom;
            exp_mem[a] = mem[a];
        end
        for (int r = 0; r < `MPU_NUM_REGS; r++) begin
            model_size[r] = '{rows: 3'd1, cols: 3'd1};
            for (int i = 0; i < `MPU_MAX_M * `MPU_MAX_N; i++) begin
                model_mat[r][i] = '0;
            end
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        reset_idle();
        round_trip();
        add_sub_mix();
        store_order();
        busy_done_protocol();
        random_sequence();

        $display("Summary: %0d tests, %0d with errors, %0d errors in total",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the instruction count
    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYC);
        $display("Test failed");
        $finish;
    end

endmodule : tb_mpu

//--- run.sh
#!/bin/sh
# Compile and run the matrix unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=tb_mpu_sim

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_mpu -o "$SIM"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
